// ==== unicore_pkg.sv ====
// Address map and command types for a single tile with fixed 40-bit addresses and 64-bit data
package unicore_pkg;

  localparam int PADDR_WIDTH  = 40;
  localparam int DWORD_WIDTH  = 64;
  localparam int TILE_WIDTH   = 8;
  localparam int DEV_WIDTH    = 4;
  localparam int OFFSET_WIDTH = 20;
  localparam int UPPER_WIDTH  = PADDR_WIDTH - TILE_WIDTH - DEV_WIDTH - OFFSET_WIDTH;

  // Everything below this address is a local device access
  localparam logic [PADDR_WIDTH-1:0] DRAM_BASE_ADDR = 40'h00_8000_0000;

  localparam logic [DEV_WIDTH-1:0] CLINT_DEV = 4'd1;
  localparam logic [DEV_WIDTH-1:0] CFG_DEV   = 4'd2;

  localparam logic [OFFSET_WIDTH-1:0] CFG_FREEZE_OFFSET  = 20'h0_0000;
  localparam logic [OFFSET_WIDTH-1:0] CFG_CORE_ID_OFFSET = 20'h0_0008;

  localparam logic [OFFSET_WIDTH-1:0] CLINT_MSIP_OFFSET     = 20'h0_0000;
  localparam logic [OFFSET_WIDTH-1:0] CLINT_MTIMECMP_OFFSET = 20'h0_4000;
  localparam logic [OFFSET_WIDTH-1:0] CLINT_MTIME_OFFSET    = 20'h0_BFF8;

  typedef struct packed {
    logic [UPPER_WIDTH-1:0]  upper;
    logic [TILE_WIDTH-1:0]   tile;
    logic [DEV_WIDTH-1:0]    dev;
    logic [OFFSET_WIDTH-1:0] offset;
  } local_addr_s;

  // Same address word, seen raw for the DRAM compare or split into local fields
  typedef union packed {
    logic [PADDR_WIDTH-1:0] raw;
    local_addr_s            loc;
  } paddr_u;

  typedef enum logic {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e                op;
    paddr_u                 addr;
    logic [DWORD_WIDTH-1:0] data;
  } mem_cmd_s;

  typedef struct packed {
    logic [DWORD_WIDTH-1:0] data;
    logic                   err;
  } mem_resp_s;

  typedef enum logic [1:0] {
    e_dev_cfg      = 2'd0,
    e_dev_clint    = 2'd1,
    e_dev_loopback = 2'd2
  } dev_sel_e;

  typedef struct packed {
    logic [DWORD_WIDTH-1:0] rdata;
    logic                   v;
  } dev_resp_s;

endpackage

// ==== unicore_cmd_decode.sv ====
// Accepts one command at a time and holds off new commands until its response is taken
`timescale 1ns/10ps

module unicore_cmd_decode
  (input                                          clk_i
   , input                                        rst_n_i

   , input  unicore_pkg::mem_cmd_s                cmd_i
   , input                                        cmd_v_i
   , output logic                                 cmd_ready_and_o

   , input  [unicore_pkg::TILE_WIDTH-1:0]         core_id_i
   , input                                        resp_done_i

   , output unicore_pkg::mem_cmd_s                req_o
   , output unicore_pkg::dev_sel_e                req_sel_o
   , output logic                                 cfg_v_o
   , output logic                                 clint_v_o
   , output logic                                 loop_v_o
  );

  logic busy_r;
  logic req_v_r;
  logic accept;
  logic is_local, is_my_tile;
  unicore_pkg::dev_sel_e sel_n;

  assign cmd_ready_and_o = ~busy_r;
  assign accept          = cmd_v_i & cmd_ready_and_o;

  assign is_local   = (cmd_i.addr.raw < unicore_pkg::DRAM_BASE_ADDR);
  assign is_my_tile = is_local & (cmd_i.addr.loc.tile == core_id_i);

  always_comb
  begin
    if (is_my_tile && (cmd_i.addr.loc.dev == unicore_pkg::CFG_DEV))
      sel_n = unicore_pkg::e_dev_cfg;
    else if (is_my_tile && (cmd_i.addr.loc.dev == unicore_pkg::CLINT_DEV))
      sel_n = unicore_pkg::e_dev_clint;
    else
      sel_n = unicore_pkg::e_dev_loopback;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      busy_r  <= 1'b0;
      req_v_r <= 1'b0;
    end
    else
    begin
      req_v_r <= accept;
      if (accept)
        busy_r <= 1'b1;
      else if (resp_done_i)
        busy_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      req_o     <= cmd_i;
      req_sel_o <= sel_n;
    end
  end

  assign cfg_v_o   = req_v_r & (req_sel_o == unicore_pkg::e_dev_cfg);
  assign clint_v_o = req_v_r & (req_sel_o == unicore_pkg::e_dev_clint);
  assign loop_v_o  = req_v_r & (req_sel_o == unicore_pkg::e_dev_loopback);

  // A response completes only for the command in flight, after its strobe
  a_done_when_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_done_i |-> (busy_r && !req_v_r));

endmodule

// ==== unicore_cfg_slice.sv ====
// Freeze and core id registers only, with unmapped offsets reading zero and dropping writes
`timescale 1ns/10ps

module unicore_cfg_slice
  (input                                          clk_i
   , input                                        rst_n_i

   , input  unicore_pkg::mem_cmd_s                req_i
   , input                                        v_i
   , output unicore_pkg::dev_resp_s               resp_o

   , output logic [unicore_pkg::TILE_WIDTH-1:0]   core_id_o
   , output logic                                 freeze_o
  );

  logic wr_v;
  logic [unicore_pkg::OFFSET_WIDTH-1:0] offset;

  assign offset = req_i.addr.loc.offset;
  assign wr_v   = v_i & (req_i.op == unicore_pkg::e_mem_wr);

  // Core held frozen out of reset until software releases it
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      freeze_o  <= 1'b1;
      core_id_o <= '0;
    end
    else if (wr_v)
    begin
      if (offset == unicore_pkg::CFG_FREEZE_OFFSET)
        freeze_o <= req_i.data[0];
      else if (offset == unicore_pkg::CFG_CORE_ID_OFFSET)
        core_id_o <= req_i.data[unicore_pkg::TILE_WIDTH-1:0];
    end
  end

  always_comb
  begin
    resp_o.v     = v_i;
    resp_o.rdata = '0;
    if (offset == unicore_pkg::CFG_FREEZE_OFFSET)
      resp_o.rdata = {{(unicore_pkg::DWORD_WIDTH-1){1'b0}}, freeze_o};
    else if (offset == unicore_pkg::CFG_CORE_ID_OFFSET)
      resp_o.rdata = {{(unicore_pkg::DWORD_WIDTH-unicore_pkg::TILE_WIDTH){1'b0}}, core_id_o};
  end

endmodule

// ==== unicore_clint_slice.sv ====
// Machine timer ticks on clk_i, not a separate real-time clock, and msip keeps only bit 0
`timescale 1ns/10ps

module unicore_clint_slice
  (input                                          clk_i
   , input                                        rst_n_i

   , input  unicore_pkg::mem_cmd_s                req_i
   , input                                        v_i
   , output unicore_pkg::dev_resp_s               resp_o

   , output logic                                 timer_irq_o
   , output logic                                 software_irq_o
  );

  logic [unicore_pkg::DWORD_WIDTH-1:0] mtime_r;
  logic [unicore_pkg::DWORD_WIDTH-1:0] mtimecmp_r;
  logic msip_r;
  logic wr_v;
  logic [unicore_pkg::OFFSET_WIDTH-1:0] offset;

  assign offset = req_i.addr.loc.offset;
  assign wr_v   = v_i & (req_i.op == unicore_pkg::e_mem_wr);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mtime_r     <= '0;
      mtimecmp_r  <= '1;
      msip_r      <= 1'b0;
      timer_irq_o <= 1'b0;
    end
    else
    begin
      // A write to mtime replaces this cycle's increment
      if (wr_v && (offset == unicore_pkg::CLINT_MTIME_OFFSET))
        mtime_r <= req_i.data;
      else
        mtime_r <= mtime_r + 1'b1;

      if (wr_v && (offset == unicore_pkg::CLINT_MTIMECMP_OFFSET))
        mtimecmp_r <= req_i.data;

      if (wr_v && (offset == unicore_pkg::CLINT_MSIP_OFFSET))
        msip_r <= req_i.data[0];

      timer_irq_o <= (mtime_r >= mtimecmp_r);
    end
  end

  assign software_irq_o = msip_r;

  always_comb
  begin
    resp_o.v = v_i;
    case (offset)
      unicore_pkg::CLINT_MSIP_OFFSET:
        resp_o.rdata = {{(unicore_pkg::DWORD_WIDTH-1){1'b0}}, msip_r};
      unicore_pkg::CLINT_MTIMECMP_OFFSET:
        resp_o.rdata = mtimecmp_r;
      unicore_pkg::CLINT_MTIME_OFFSET:
        resp_o.rdata = mtime_r;
      default:
        resp_o.rdata = '0;
    endcase
  end

endmodule

// ==== unicore_resp_arb.sv ====
// Holds one response at a time and relies on the decoder to keep a single command in flight
`timescale 1ns/10ps

module unicore_resp_arb
  (input                                          clk_i
   , input                                        rst_n_i

   , input  unicore_pkg::dev_sel_e                sel_i
   , input                                        loop_v_i
   , input  unicore_pkg::dev_resp_s               cfg_resp_i
   , input  unicore_pkg::dev_resp_s               clint_resp_i

   , output unicore_pkg::mem_resp_s               resp_o
   , output logic                                 resp_v_o
   , input                                        resp_ready_and_i
   , output logic                                 resp_done_o
  );

  unicore_pkg::mem_resp_s sel_resp;
  logic sel_v;

  always_comb
  begin
    sel_resp = '0;
    sel_v    = 1'b0;
    case (sel_i)
      unicore_pkg::e_dev_cfg:
      begin
        sel_resp.data = cfg_resp_i.rdata;
        sel_v         = cfg_resp_i.v;
      end
      unicore_pkg::e_dev_clint:
      begin
        sel_resp.data = clint_resp_i.rdata;
        sel_v         = clint_resp_i.v;
      end
      default:
      begin
        // Loopback answers with zero data and an error
        sel_resp.err = 1'b1;
        sel_v        = loop_v_i;
      end
    endcase
  end

  assign resp_done_o = resp_v_o & resp_ready_and_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_o <= 1'b0;
    else if (sel_v)
      resp_v_o <= 1'b1;
    else if (resp_done_o)
      resp_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (sel_v)
      resp_o <= sel_resp;
  end

  // Decoder must not issue a new command while a response waits
  a_no_overrun: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_o |-> !(loop_v_i | cfg_resp_i.v | clint_resp_i.v));

endmodule

// ==== unicore_top.sv ====
// Single-tile device hub with config and CLINT slices, every other address loops back an error
`timescale 1ns/10ps

module unicore_top
  (input                                          clk_i
   , input                                        rst_n_i

   , input  unicore_pkg::mem_cmd_s                cmd_i
   , input                                        cmd_v_i
   , output logic                                 cmd_ready_and_o

   , output unicore_pkg::mem_resp_s               resp_o
   , output logic                                 resp_v_o
   , input                                        resp_ready_and_i

   , output logic                                 freeze_o
   , output logic                                 timer_irq_o
   , output logic                                 software_irq_o
  );

  unicore_pkg::mem_cmd_s  req;
  unicore_pkg::dev_sel_e  req_sel;
  unicore_pkg::dev_resp_s cfg_resp, clint_resp;
  logic cfg_v, clint_v, loop_v;
  logic resp_done;
  logic [unicore_pkg::TILE_WIDTH-1:0] core_id;

  unicore_cmd_decode decode
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_and_o(cmd_ready_and_o)
     ,.core_id_i(core_id)
     ,.resp_done_i(resp_done)
     ,.req_o(req)
     ,.req_sel_o(req_sel)
     ,.cfg_v_o(cfg_v)
     ,.clint_v_o(clint_v)
     ,.loop_v_o(loop_v)
    );

  unicore_cfg_slice cfgs
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.req_i(req)
     ,.v_i(cfg_v)
     ,.resp_o(cfg_resp)
     ,.core_id_o(core_id)
     ,.freeze_o(freeze_o)
    );

  unicore_clint_slice clint
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.req_i(req)
     ,.v_i(clint_v)
     ,.resp_o(clint_resp)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
    );

  unicore_resp_arb resp_arb
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.sel_i(req_sel)
     ,.loop_v_i(loop_v)
     ,.cfg_resp_i(cfg_resp)
     ,.clint_resp_i(clint_resp)
     ,.resp_o(resp_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_ready_and_i(resp_ready_and_i)
     ,.resp_done_o(resp_done)
    );

endmodule

// ==== tb_unicore.sv ====
// Replays unicore_trace.txt from the project root with one command in flight and random stalls
`timescale 1ns/10ps

module tb_unicore;

  localparam int TIMEOUT_CYCLES = 50;

  logic clk_i;
  logic rst_n_i;
  unicore_pkg::mem_cmd_s  cmd;
  logic cmd_v;
  logic cmd_ready_and;
  unicore_pkg::mem_resp_s resp;
  logic resp_v;
  logic resp_ready_and;
  logic freeze;
  logic timer_irq;
  logic software_irq;

  // Core id the DUT should hold after the config writes so far
  logic [unicore_pkg::TILE_WIDTH-1:0] core_id_m;
  logic [63:0] last_mtime;

  unicore_top UUT
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.cmd_i(cmd)
     ,.cmd_v_i(cmd_v)
     ,.cmd_ready_and_o(cmd_ready_and)
     ,.resp_o(resp)
     ,.resp_v_o(resp_v)
     ,.resp_ready_and_i(resp_ready_and)
     ,.freeze_o(freeze)
     ,.timer_irq_o(timer_irq)
     ,.software_irq_o(software_irq)
    );

  always #50 clk_i = ~clk_i;

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, actual, expected);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    $display("TB FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic wait_irq_level(input logic timer, input logic level);
    int cycles;
    logic seen;
    cycles = 0;
    seen = timer ? timer_irq : software_irq;
    while (seen !== level)
    begin
      @(posedge clk_i);
      seen = timer ? timer_irq : software_irq;
      cycles++;
      if (seen !== level && cycles > TIMEOUT_CYCLES)
        give_up(timer ? "timer_irq_o level" : "software_irq_o level");
    end
  endtask

  // Outputs are sampled at the rising edge before the flops update and inputs change by NBA
  task automatic run_command(input logic op, input logic [39:0] addr, input logic [63:0] wdata,
                             output unicore_pkg::mem_resp_s got);
    int cycles;
    int unsigned stall;
    logic taken;
    logic held_v;
    unicore_pkg::mem_resp_s held;
    stall = $urandom % 4;
    cmd.op       <= unicore_pkg::mem_op_e'(op);
    cmd.addr.raw <= addr;
    cmd.data     <= wdata;
    cmd_v        <= 1'b1;
    cycles = 0;
    taken = 1'b0;
    while (!taken)
    begin
      @(posedge clk_i);
      taken = cmd_ready_and;
      cycles++;
      if (!taken && cycles > TIMEOUT_CYCLES)
        give_up("cmd_ready_and_o");
    end
    cmd_v          <= 1'b0;
    resp_ready_and <= (stall == 0);
    cycles = 0;
    held_v = 1'b0;
    held = '0;
    taken = 1'b0;
    while (!taken)
    begin
      @(posedge clk_i);
      cycles++;
      check_value(64'(cmd_ready_and), 64'd0, "cmd_ready_and_o with a command outstanding");
      if (resp_v)
      begin
        if (held_v)
        begin
          check_value(resp.data, held.data, "resp_o data held under back-pressure");
          check_value(64'(resp.err), 64'(held.err), "resp_o err held under back-pressure");
        end
        held = resp;
        held_v = 1'b1;
        if (resp_ready_and)
          taken = 1'b1;
        else
        begin
          stall--;
          if (stall == 0)
            resp_ready_and <= 1'b1;
        end
      end
      if (!taken && cycles > TIMEOUT_CYCLES)
        give_up("resp_v_o");
    end
    got = held;
    resp_ready_and <= 1'b0;
    @(posedge clk_i);
    check_value(64'(cmd_ready_and), 64'd1, "cmd_ready_and_o after the response");
    check_value(64'(resp_v), 64'd0, "resp_v_o after the response");
  endtask

  initial
  begin
    int fd;
    int code;
    int count;
    int ncmd;
    string line;
    logic [63:0] op, addr, wdata, exp_rdata, exp_err, chk;
    unicore_pkg::mem_resp_s got;
    unicore_pkg::paddr_u pa;
    logic is_mine;

    void'($urandom(32'h1e63));
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    cmd = '0;
    cmd_v = 1'b0;
    resp_ready_and = 1'b0;
    core_id_m = '0;
    last_mtime = '0;
    ncmd = 0;

    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_value(64'(cmd_ready_and), 64'd1, "cmd_ready_and_o after reset");
    check_value(64'(resp_v), 64'd0, "resp_v_o after reset");
    check_value(64'(freeze), 64'd1, "freeze_o after reset");
    check_value(64'(timer_irq), 64'd0, "timer_irq_o after reset");
    check_value(64'(software_irq), 64'd0, "software_irq_o after reset");

    fd = $fopen("unicore_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open unicore_trace.txt for reading");
      $display("TB FAILED");
      $fatal(1, "missing trace");
    end

    while (!$feof(fd))
    begin
      code = $fgets(line, fd);
      count = $sscanf(line, "%h %h %h %h %h %h", op, addr, wdata, exp_rdata, exp_err, chk);
      if (code > 0 && count == 6)
      begin
        ncmd++;
        run_command(op[0], addr[39:0], wdata, got);
        check_value(64'(got.err), exp_err, "response err");
        if (chk[0])
          check_value(got.data, exp_rdata, "response data");

        pa.raw = addr[39:0];
        is_mine = (pa.raw < unicore_pkg::DRAM_BASE_ADDR) && (pa.loc.tile == core_id_m);
        if (is_mine && op[0] && pa.loc.dev == unicore_pkg::CFG_DEV)
        begin
          if (pa.loc.offset == unicore_pkg::CFG_FREEZE_OFFSET)
            check_value(64'(freeze), 64'(wdata[0]), "freeze_o after write");
          else if (pa.loc.offset == unicore_pkg::CFG_CORE_ID_OFFSET)
            core_id_m = wdata[unicore_pkg::TILE_WIDTH-1:0];
        end
        if (is_mine && pa.loc.dev == unicore_pkg::CLINT_DEV)
        begin
          if (op[0] && pa.loc.offset == unicore_pkg::CLINT_MSIP_OFFSET)
            wait_irq_level(1'b0, wdata[0]);
          // mtime starts near zero so only an all-ones compare keeps the timer quiet
          if (op[0] && pa.loc.offset == unicore_pkg::CLINT_MTIMECMP_OFFSET)
            wait_irq_level(1'b1, wdata != '1);
          if (!op[0] && pa.loc.offset == unicore_pkg::CLINT_MTIME_OFFSET)
          begin
            check_value(64'(got.data > last_mtime), 64'd1, "mtime advancing between reads");
            last_mtime = got.data;
          end
        end
      end
      else if (code > 0 && line.getc(0) != 8'h23 && line.getc(0) != 8'h0a)
      begin
        $display("Malformed trace line: %s", line);
        $display("TB FAILED");
        $fatal(1, "bad trace");
      end
    end
    $fclose(fd);

    if (ncmd == 0)
    begin
      $display("Trace held no commands");
      $display("TB FAILED");
      $fatal(1, "empty trace");
    end
    else
    begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// ==== unicore_trace.txt ====
# Hex columns op addr wdata exp_rdata exp_err check_data with op 1 for a write
# Local addresses carry the tile in bits 31:24 and the device in bits 23:20
0 0000200000 0000000000000000 0000000000000001 0 1
1 0000200000 0000000000000000 0000000000000000 0 0
1 0000200008 0000000000000005 0000000000000000 0 0
0 0005200008 0000000000000000 0000000000000005 0 1
0 0005200000 0000000000000000 0000000000000000 0 1
0 0000200008 0000000000000000 0000000000000000 1 1
0 0080000000 0000000000000000 0000000000000000 1 1
1 00ffff0000 00000000deadbeef 0000000000000000 1 1
0 0005300000 0000000000000000 0000000000000000 1 1
0 0005104000 0000000000000000 ffffffffffffffff 0 1
1 0005104000 0000000000000000 0000000000000000 0 0
0 0005104000 0000000000000000 0000000000000000 0 1
1 0005104000 ffffffffffffffff 0000000000000000 0 0
0 0005104000 0000000000000000 ffffffffffffffff 0 1
1 0005100000 0000000000000001 0000000000000000 0 0
0 0005100000 0000000000000000 0000000000000001 0 1
1 0005100000 0000000000000000 0000000000000000 0 0
0 0005100000 0000000000000000 0000000000000000 0 1
0 000510bff8 0000000000000000 0000000000000000 0 0
0 000510bff8 0000000000000000 0000000000000000 0 0
0 0005100010 0000000000000000 0000000000000000 0 1

// ==== unicore.f ====
unicore_pkg.sv
unicore_cmd_decode.sv
unicore_cfg_slice.sv
unicore_clint_slice.sv
unicore_resp_arb.sv
unicore_top.sv
tb_unicore.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_unicore -f unicore.f
out=$(./obj_dir/Vtb_unicore 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'TB PASSED'; then
  exit 0
fi
exit 1
